// ==== hw/issue_config.svh ====
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Issue slots per cycle
`define ISSUE_W 2

// Architectural register file
`define REG_NUM 32
`define REG_AW  5

// Data word
`define DATA_W  32

// Major opcode field of the instruction word
`define OPC_MSB 31
`define OPC_LSB 26

`endif

// ==== hw/issue_pkg.sv ====
`include "issue_config.svh"

package issue_pkg;

   typedef logic [31:0]                    insn_t;
   typedef logic [`REG_AW-1:0]             reg_addr_t;
   typedef logic [`DATA_W-1:0]             data_t;
   typedef logic [31:0]                    pc_t;
   typedef logic [3:0]                     alu_opc_t;
   typedef logic [1:0]                     lsu_opc_t;
   typedef logic [0:0]                     bru_opc_t;
   typedef logic [`ISSUE_W-1:0]            slot_mask_t;
   typedef logic [$clog2(`ISSUE_W+1)-1:0]  pop_cnt_t;

   // Major opcodes
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_NOP  = 6'd0;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_ADD  = 6'd1;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_SUB  = 6'd2;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_AND  = 6'd3;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_OR   = 6'd4;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_ADDI = 6'd5;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_LD   = 6'd6;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_ST   = 6'd7;
   localparam logic [`OPC_MSB-`OPC_LSB:0] OPC_BEQ  = 6'd8;

   // Bit positions in the one-hot unit opcodes
   localparam int ALU_ADD   = 0;
   localparam int ALU_SUB   = 1;
   localparam int ALU_AND   = 2;
   localparam int ALU_OR    = 3;
   localparam int LSU_LOAD  = 0;
   localparam int LSU_STORE = 1;

endpackage

// ==== hw/insn_dec.sv ====
`timescale 1ns/1ps
`include "issue_config.svh"

module insn_dec
   import issue_pkg::*;
(
   input  insn_t     ins,
   input  logic      valid,
   output alu_opc_t  alu_opc,
   output lsu_opc_t  lsu_opc,
   output bru_opc_t  bru_opc,
   output data_t     imm,
   output logic      rf_we,
   output reg_addr_t rf_waddr,
   output logic      rs1_re,
   output reg_addr_t rs1_addr,
   output logic      rs2_re,
   output reg_addr_t rs2_addr,
   output logic      single_fu
);
   logic [`OPC_MSB-`OPC_LSB:0] opc;
   logic                       wr_rd;

   assign opc      = ins[`OPC_MSB:`OPC_LSB];
   assign rf_waddr = ins[25:21];
   assign rs1_addr = ins[20:16];
   assign rs2_addr = ins[15:11];
   assign imm      = {{(`DATA_W-16){ins[15]}}, ins[15:0]};

   always_comb
   begin
      alu_opc = '0;
      lsu_opc = '0;
      bru_opc = '0;
      wr_rd   = 1'b0;
      rs1_re  = 1'b0;
      rs2_re  = 1'b0;
      // Unknown opcodes fall through as NOP
      if (valid)
      begin
         case (opc)
            OPC_ADD, OPC_SUB, OPC_AND, OPC_OR:
            begin
               alu_opc[ALU_ADD] = (opc == OPC_ADD);
               alu_opc[ALU_SUB] = (opc == OPC_SUB);
               alu_opc[ALU_AND] = (opc == OPC_AND);
               alu_opc[ALU_OR]  = (opc == OPC_OR);
               wr_rd  = 1'b1;
               rs1_re = 1'b1;
               rs2_re = 1'b1;
            end
            OPC_ADDI:
            begin
               alu_opc[ALU_ADD] = 1'b1;
               wr_rd  = 1'b1;
               rs1_re = 1'b1;
            end
            OPC_LD:
            begin
               lsu_opc[LSU_LOAD] = 1'b1;
               wr_rd  = 1'b1;
               rs1_re = 1'b1;
            end
            OPC_ST:
            begin
               lsu_opc[LSU_STORE] = 1'b1;
               rs1_re = 1'b1;
               rs2_re = 1'b1;
            end
            OPC_BEQ:
            begin
               bru_opc = 1'b1;
               rs1_re  = 1'b1;
               rs2_re  = 1'b1;
            end
            default:
            begin
               wr_rd = 1'b0;
            end
         endcase
      end
   end

   // r0 is hardwired, never written
   assign rf_we = wr_rd & (rf_waddr != '0);

   // LSU and BRU exist once
   assign single_fu = (|lsu_opc) | (|bru_opc);

endmodule

// ==== hw/operand_bypass.sv ====
`timescale 1ns/1ps
`include "issue_config.svh"

module operand_bypass
   import issue_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [2*`ISSUE_W-1:0]      re,
   input  reg_addr_t [2*`ISSUE_W-1:0] raddr,
   input  data_t [2*`ISSUE_W-1:0]     rf_rdata,
   input  slot_mask_t                 s1_we,
   input  slot_mask_t                 s2_we,
   input  slot_mask_t                 s3_we,
   input  reg_addr_t [`ISSUE_W-1:0]   s1_waddr,
   input  reg_addr_t [`ISSUE_W-1:0]   s2_waddr,
   input  reg_addr_t [`ISSUE_W-1:0]   s3_waddr,
   input  data_t [`ISSUE_W-1:0]       s1_wdata,
   input  data_t [`ISSUE_W-1:0]       s2_wdata,
   input  data_t [`ISSUE_W-1:0]       s3_wdata,
   input  logic                       s1_load0,
   output data_t [2*`ISSUE_W-1:0]     byp_dout,
   output slot_mask_t                 raw_load0
);
   reg_addr_t [2*`ISSUE_W-1:0] raddr_q;
   slot_mask_t                 stg_we    [3];
   reg_addr_t [`ISSUE_W-1:0]   stg_waddr [3];
   data_t [`ISSUE_W-1:0]       stg_wdata [3];
   logic [2*`ISSUE_W-1:0]      port_load0;

   // Address follows the register file read, same enables
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         raddr_q <= '0;
      else
      begin
         for (int p = 0; p < 2*`ISSUE_W; p++)
         begin
            if (re[p])
               raddr_q[p] <= raddr[p];
         end
      end
   end

   // Index 0 is the youngest result (s1)
   assign stg_we[0]    = s1_we;
   assign stg_we[1]    = s2_we;
   assign stg_we[2]    = s3_we;
   assign stg_waddr[0] = s1_waddr;
   assign stg_waddr[1] = s2_waddr;
   assign stg_waddr[2] = s3_waddr;
   assign stg_wdata[0] = s1_wdata;
   assign stg_wdata[1] = s2_wdata;
   assign stg_wdata[2] = s3_wdata;

   // Walk from lowest to highest priority so the last match wins
   always_comb
   begin
      for (int p = 0; p < 2*`ISSUE_W; p++)
      begin
         byp_dout[p] = rf_rdata[p];
         for (int st = 2; st >= 0; st--)
         begin
            for (int k = 0; k < `ISSUE_W; k++)
            begin
               if (stg_we[st][k] && (stg_waddr[st][k] == raddr_q[p]))
                  byp_dout[p] = stg_wdata[st][k];
            end
         end
         if (raddr_q[p] == '0)
            byp_dout[p] = '0;
      end
   end

   // Load result in s1 is not ready yet
   always_comb
   begin
      for (int p = 0; p < 2*`ISSUE_W; p++)
      begin
         port_load0[p] = re[p] & s1_we[0] & s1_load0 &
                         (s1_waddr[0] == raddr[p]) & (raddr[p] != '0);
      end
      for (int k = 0; k < `ISSUE_W; k++)
         raw_load0[k] = port_load0[2*k] | port_load0[2*k+1];
   end

endmodule

// ==== hw/arch_regfile.sv ====
`timescale 1ns/1ps
`include "issue_config.svh"

module arch_regfile
   import issue_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [2*`ISSUE_W-1:0]      re,
   input  reg_addr_t [2*`ISSUE_W-1:0] raddr,
   output data_t [2*`ISSUE_W-1:0]     rdata,
   input  slot_mask_t                 we,
   input  reg_addr_t [`ISSUE_W-1:0]   waddr,
   input  data_t [`ISSUE_W-1:0]       wdata
);
   data_t                  regs [`REG_NUM];
   data_t [2*`ISSUE_W-1:0] rd_next;

   // Later slot overwrites earlier one on the same address
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < `ISSUE_W; k++)
      begin
         if (we[k] && (waddr[k] != '0))
            regs[waddr[k]] <= wdata[k];
      end
   end

   // Write data in the same cycle is passed to the read
   always_comb
   begin
      for (int p = 0; p < 2*`ISSUE_W; p++)
      begin
         rd_next[p] = regs[raddr[p]];
         for (int k = 0; k < `ISSUE_W; k++)
         begin
            if (we[k] && (waddr[k] == raddr[p]))
               rd_next[p] = wdata[k];
         end
         if (raddr[p] == '0)
            rd_next[p] = '0;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rdata <= '0;
      else
      begin
         for (int p = 0; p < 2*`ISSUE_W; p++)
         begin
            if (re[p])
               rdata[p] <= rd_next[p];
         end
      end
   end

endmodule

// ==== hw/issue_stage.sv ====
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage
   import issue_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       flush,
   input  logic                       stall,
   input  slot_mask_t                 id_valid,
   input  insn_t [`ISSUE_W-1:0]       id_ins,
   input  pc_t [`ISSUE_W-1:0]         id_pc,
   output pop_cnt_t                   id_pop_cnt,
   output slot_mask_t                 ex_valid,
   output alu_opc_t [`ISSUE_W-1:0]    ex_alu_opc,
   output lsu_opc_t [`ISSUE_W-1:0]    ex_lsu_opc,
   output bru_opc_t [`ISSUE_W-1:0]    ex_bru_opc,
   output pc_t [`ISSUE_W-1:0]         ex_pc,
   output data_t [`ISSUE_W-1:0]       ex_imm,
   output data_t [`ISSUE_W-1:0]       ex_operand1,
   output data_t [`ISSUE_W-1:0]       ex_operand2,
   output slot_mask_t                 ex_rf_we,
   output reg_addr_t [`ISSUE_W-1:0]   ex_rf_waddr,
   input  slot_mask_t                 s1_we,
   input  slot_mask_t                 s2_we,
   input  slot_mask_t                 s3_we,
   input  reg_addr_t [`ISSUE_W-1:0]   s1_waddr,
   input  reg_addr_t [`ISSUE_W-1:0]   s2_waddr,
   input  reg_addr_t [`ISSUE_W-1:0]   s3_waddr,
   input  data_t [`ISSUE_W-1:0]       s1_wdata,
   input  data_t [`ISSUE_W-1:0]       s2_wdata,
   input  data_t [`ISSUE_W-1:0]       s3_wdata,
   input  logic                       s1_load0,
   output logic [2*`ISSUE_W-1:0]      arf_re,
   output reg_addr_t [2*`ISSUE_W-1:0] arf_raddr,
   input  data_t [2*`ISSUE_W-1:0]     arf_rdata
);
   logic                     p_ce;
   logic                     ex_ld;
   alu_opc_t [`ISSUE_W-1:0]  dec_alu_opc;
   lsu_opc_t [`ISSUE_W-1:0]  dec_lsu_opc;
   bru_opc_t [`ISSUE_W-1:0]  dec_bru_opc;
   data_t [`ISSUE_W-1:0]     dec_imm;
   slot_mask_t               dec_rf_we;
   reg_addr_t [`ISSUE_W-1:0] dec_rf_waddr;
   slot_mask_t               rs1_re;
   slot_mask_t               rs2_re;
   reg_addr_t [`ISSUE_W-1:0] rs1_addr;
   reg_addr_t [`ISSUE_W-1:0] rs2_addr;
   slot_mask_t               single_fu;
   slot_mask_t               raw_load0;
   slot_mask_t               raw_dep;
   slot_mask_t               issue;
   slot_mask_t               rs2_re_q;
   data_t [2*`ISSUE_W-1:0]   byp_dout;

   assign p_ce  = ~stall;
   assign ex_ld = p_ce | flush;

   for (genvar i = 0; i < `ISSUE_W; i++)
   begin : g_dec
      insn_dec u_dec (
         .ins       (id_ins[i]),
         .valid     (id_valid[i]),
         .alu_opc   (dec_alu_opc[i]),
         .lsu_opc   (dec_lsu_opc[i]),
         .bru_opc   (dec_bru_opc[i]),
         .imm       (dec_imm[i]),
         .rf_we     (dec_rf_we[i]),
         .rf_waddr  (dec_rf_waddr[i]),
         .rs1_re    (rs1_re[i]),
         .rs1_addr  (rs1_addr[i]),
         .rs2_re    (rs2_re[i]),
         .rs2_addr  (rs2_addr[i]),
         .single_fu (single_fu[i])
      );
   end

   // RAW against older slots in the window, plus load-use on s1
   always_comb
   begin
      for (int k = 0; k < `ISSUE_W; k++)
      begin
         raw_dep[k] = raw_load0[k];
         for (int j = 0; j < k; j++)
         begin
            if (dec_rf_we[j] &&
                ((rs1_re[k] && (rs1_addr[k] == dec_rf_waddr[j])) ||
                 (rs2_re[k] && (rs2_addr[k] == dec_rf_waddr[j]))))
               raw_dep[k] = 1'b1;
         end
      end
   end

   // Only a leading run of slots may go; slot 0 can always take the single unit
   always_comb
   begin
      issue[0] = id_valid[0] & ~raw_dep[0];
      for (int k = 1; k < `ISSUE_W; k++)
         issue[k] = issue[k-1] & id_valid[k] & ~single_fu[k] & ~raw_dep[k];
   end

   always_comb
   begin
      id_pop_cnt = '0;
      for (int k = 0; k < `ISSUE_W; k++)
      begin
         if (issue[k] && p_ce)
            id_pop_cnt = id_pop_cnt + pop_cnt_t'(1);
      end
   end

   // Register file reads, held while stalled
   always_comb
   begin
      for (int k = 0; k < `ISSUE_W; k++)
      begin
         arf_re[2*k]      = p_ce & rs1_re[k];
         arf_re[2*k+1]    = p_ce & rs2_re[k];
         arf_raddr[2*k]   = rs1_addr[k];
         arf_raddr[2*k+1] = rs2_addr[k];
      end
   end

   operand_bypass u_bypass (
      .clk       (clk),
      .rst_n     (rst_n),
      .re        (arf_re),
      .raddr     (arf_raddr),
      .rf_rdata  (arf_rdata),
      .s1_we     (s1_we),
      .s2_we     (s2_we),
      .s3_we     (s3_we),
      .s1_waddr  (s1_waddr),
      .s2_waddr  (s2_waddr),
      .s3_waddr  (s3_waddr),
      .s1_wdata  (s1_wdata),
      .s2_wdata  (s2_wdata),
      .s3_wdata  (s3_wdata),
      .s1_load0  (s1_load0),
      .byp_dout  (byp_dout),
      .raw_load0 (raw_load0)
   );

   always_comb
   begin
      for (int k = 0; k < `ISSUE_W; k++)
      begin
         ex_operand1[k] = byp_dout[2*k];
         ex_operand2[k] = rs2_re_q[k] ? byp_dout[2*k+1] : ex_imm[k];
      end
   end

   // Flush kills the slots even during a stall
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ex_valid <= '0;
      else if (ex_ld)
         ex_valid <= flush ? '0 : issue;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         ex_alu_opc  <= dec_alu_opc;
         ex_lsu_opc  <= dec_lsu_opc;
         ex_bru_opc  <= dec_bru_opc;
         ex_pc       <= id_pc;
         ex_imm      <= dec_imm;
         ex_rf_we    <= dec_rf_we;
         ex_rf_waddr <= dec_rf_waddr;
         rs2_re_q    <= rs2_re;
      end
   end

endmodule

// ==== hw/issue_top.sv ====
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_top
   import issue_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   input  logic                     stall,
   input  slot_mask_t               id_valid,
   input  insn_t [`ISSUE_W-1:0]     id_ins,
   input  pc_t [`ISSUE_W-1:0]       id_pc,
   output pop_cnt_t                 id_pop_cnt,
   output slot_mask_t               ex_valid,
   output alu_opc_t [`ISSUE_W-1:0]  ex_alu_opc,
   output lsu_opc_t [`ISSUE_W-1:0]  ex_lsu_opc,
   output bru_opc_t [`ISSUE_W-1:0]  ex_bru_opc,
   output pc_t [`ISSUE_W-1:0]       ex_pc,
   output data_t [`ISSUE_W-1:0]     ex_imm,
   output data_t [`ISSUE_W-1:0]     ex_operand1,
   output data_t [`ISSUE_W-1:0]     ex_operand2,
   output slot_mask_t               ex_rf_we,
   output reg_addr_t [`ISSUE_W-1:0] ex_rf_waddr,
   input  slot_mask_t               s1_we,
   input  slot_mask_t               s2_we,
   input  slot_mask_t               s3_we,
   input  reg_addr_t [`ISSUE_W-1:0] s1_waddr,
   input  reg_addr_t [`ISSUE_W-1:0] s2_waddr,
   input  reg_addr_t [`ISSUE_W-1:0] s3_waddr,
   input  data_t [`ISSUE_W-1:0]     s1_wdata,
   input  data_t [`ISSUE_W-1:0]     s2_wdata,
   input  data_t [`ISSUE_W-1:0]     s3_wdata,
   input  logic                     s1_load0
);
   logic [2*`ISSUE_W-1:0]      arf_re;
   reg_addr_t [2*`ISSUE_W-1:0] arf_raddr;
   data_t [2*`ISSUE_W-1:0]     arf_rdata;

   issue_stage u_issue (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .stall       (stall),
      .id_valid    (id_valid),
      .id_ins      (id_ins),
      .id_pc       (id_pc),
      .id_pop_cnt  (id_pop_cnt),
      .ex_valid    (ex_valid),
      .ex_alu_opc  (ex_alu_opc),
      .ex_lsu_opc  (ex_lsu_opc),
      .ex_bru_opc  (ex_bru_opc),
      .ex_pc       (ex_pc),
      .ex_imm      (ex_imm),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2),
      .ex_rf_we    (ex_rf_we),
      .ex_rf_waddr (ex_rf_waddr),
      .s1_we       (s1_we),
      .s2_we       (s2_we),
      .s3_we       (s3_we),
      .s1_waddr    (s1_waddr),
      .s2_waddr    (s2_waddr),
      .s3_waddr    (s3_waddr),
      .s1_wdata    (s1_wdata),
      .s2_wdata    (s2_wdata),
      .s3_wdata    (s3_wdata),
      .s1_load0    (s1_load0),
      .arf_re      (arf_re),
      .arf_raddr   (arf_raddr),
      .arf_rdata   (arf_rdata)
   );

   // s3 is the writeback stage
   arch_regfile u_arf (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (arf_re),
      .raddr (arf_raddr),
      .rdata (arf_rdata),
      .we    (s3_we),
      .waddr (s3_waddr),
      .wdata (s3_wdata)
   );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
(
   output logic clk
);

   // 4 ns period
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

endmodule

// ==== bench/issue_tb.sv ====
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_tb
   import issue_pkg::*;
();
   typedef struct {
      insn_t      i0;
      insn_t      i1;
      slot_mask_t v;
      logic       st;
      logic       fl;
      logic       s1we;
      reg_addr_t  s1a;
      data_t      s1d;
      logic       ld;
      logic       s3we;
      reg_addr_t  s3a;
      data_t      s3d;
      pop_cnt_t   pop;
   } row_t;

   logic                     clk;
   logic                     rst_n;
   logic                     flush;
   logic                     stall;
   slot_mask_t               id_valid;
   insn_t [`ISSUE_W-1:0]     id_ins;
   pc_t [`ISSUE_W-1:0]       id_pc;
   pop_cnt_t                 id_pop_cnt;
   slot_mask_t               ex_valid;
   alu_opc_t [`ISSUE_W-1:0]  ex_alu_opc;
   lsu_opc_t [`ISSUE_W-1:0]  ex_lsu_opc;
   bru_opc_t [`ISSUE_W-1:0]  ex_bru_opc;
   pc_t [`ISSUE_W-1:0]       ex_pc;
   data_t [`ISSUE_W-1:0]     ex_imm;
   data_t [`ISSUE_W-1:0]     ex_operand1;
   data_t [`ISSUE_W-1:0]     ex_operand2;
   slot_mask_t               ex_rf_we;
   reg_addr_t [`ISSUE_W-1:0] ex_rf_waddr;
   slot_mask_t               s1_we;
   slot_mask_t               s2_we;
   slot_mask_t               s3_we;
   reg_addr_t [`ISSUE_W-1:0] s1_waddr;
   reg_addr_t [`ISSUE_W-1:0] s2_waddr;
   reg_addr_t [`ISSUE_W-1:0] s3_waddr;
   data_t [`ISSUE_W-1:0]     s1_wdata;
   data_t [`ISSUE_W-1:0]     s2_wdata;
   data_t [`ISSUE_W-1:0]     s3_wdata;
   logic                     s1_load0;

   // Reference register model and expected execute-side state
   data_t       model [`REG_NUM];
   row_t        rows [$];
   logic [31:0] lfsr;
   slot_mask_t  exp_valid;
   slot_mask_t  exp_rf_we;
   alu_opc_t    exp_alu [`ISSUE_W];
   lsu_opc_t    exp_lsu [`ISSUE_W];
   bru_opc_t    exp_bru [`ISSUE_W];
   data_t       exp_imm [`ISSUE_W];
   pc_t         exp_pc [`ISSUE_W];
   reg_addr_t   exp_waddr [`ISSUE_W];
   logic        cap_r1 [`ISSUE_W];
   logic        cap_r2 [`ISSUE_W];
   reg_addr_t   cap_a1 [`ISSUE_W];
   reg_addr_t   cap_a2 [`ISSUE_W];
   data_t       cap_v1 [`ISSUE_W];
   data_t       cap_v2 [`ISSUE_W];

   tb_clock u_clk (
      .clk (clk)
   );

   issue_top issue_top_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .stall       (stall),
      .id_valid    (id_valid),
      .id_ins      (id_ins),
      .id_pc       (id_pc),
      .id_pop_cnt  (id_pop_cnt),
      .ex_valid    (ex_valid),
      .ex_alu_opc  (ex_alu_opc),
      .ex_lsu_opc  (ex_lsu_opc),
      .ex_bru_opc  (ex_bru_opc),
      .ex_pc       (ex_pc),
      .ex_imm      (ex_imm),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2),
      .ex_rf_we    (ex_rf_we),
      .ex_rf_waddr (ex_rf_waddr),
      .s1_we       (s1_we),
      .s2_we       (s2_we),
      .s3_we       (s3_we),
      .s1_waddr    (s1_waddr),
      .s2_waddr    (s2_waddr),
      .s3_waddr    (s3_waddr),
      .s1_wdata    (s1_wdata),
      .s2_wdata    (s2_wdata),
      .s3_wdata    (s3_wdata),
      .s1_load0    (s1_load0)
   );

   initial
   begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_mask(input string name, input slot_mask_t exp, input slot_mask_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_pop(input string name, input pop_cnt_t exp, input pop_cnt_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_alu(input string name, input alu_opc_t exp, input alu_opc_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_lsu(input string name, input lsu_opc_t exp, input lsu_opc_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bru(input string name, input bru_opc_t exp, input bru_opc_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_pc(input string name, input pc_t exp, input pc_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
      if (act !== exp)
      begin
         $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_word(output data_t w);
      w = '0;
      for (int b = 0; b < `DATA_W; b++)
      begin
         w = {w[`DATA_W-2:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   function automatic insn_t mk_r(input int opc, input int rd, input int rs1, input int rs2);
      return {opc[5:0], rd[4:0], rs1[4:0], rs2[4:0], 11'd0};
   endfunction

   function automatic insn_t mk_i(input int opc, input int rd, input int rs1, input int imm);
      return {opc[5:0], rd[4:0], rs1[4:0], imm[15:0]};
   endfunction

   // Each row fetches from its own address, slot 1 one word after slot 0
   function automatic pc_t slot_pc(input int r, input int k);
      return pc_t'(32'h0000_1000 + 8 * r + 4 * k);
   endfunction

   task automatic add_row(input insn_t i0, input insn_t i1, input int v, input int st,
                          input int fl, input int s1we, input int s1a, input data_t s1d,
                          input int ld, input int s3we, input int s3a, input data_t s3d,
                          input int pop);
      row_t x;
      x.i0   = i0;
      x.i1   = i1;
      x.v    = v[1:0];
      x.st   = st[0];
      x.fl   = fl[0];
      x.s1we = s1we[0];
      x.s1a  = s1a[4:0];
      x.s1d  = s1d;
      x.ld   = ld[0];
      x.s3we = s3we[0];
      x.s3a  = s3a[4:0];
      x.s3d  = s3d;
      x.pop  = pop[1:0];
      rows.push_back(x);
   endtask

   // Row columns are slot0, slot1, valid, stall, flush, s1 we/addr/data/load, s3 we/addr/data, pop
   task automatic build_table();
      add_row(mk_r(1, 3, 1, 2), mk_r(2, 4, 5, 6), 3, 0, 0, 0, 0, '0, 0, 0, 0, '0, 2);
      add_row(mk_r(3, 7, 8, 9), mk_r(4, 10, 7, 11), 3, 0, 0, 0, 0, '0, 0, 0, 0, '0, 1);
      add_row(mk_r(1, 12, 13, 14), mk_i(6, 15, 16, 8), 3, 0, 0, 0, 0, '0, 0, 0, 0, '0, 1);
      add_row(mk_r(7, 0, 17, 18), mk_r(8, 0, 19, 20), 3, 0, 0, 0, 0, '0, 0, 0, 0, '0, 1);
      add_row(mk_r(4, 20, 21, 22), mk_i(5, 23, 24, -5), 3, 0, 0,
              0, 0, '0, 0, 1, 21, 32'h5a5a_0f0f, 2);
      // Load in s1 blocks slot 0 and so the whole window
      add_row(mk_r(1, 26, 25, 1), mk_r(1, 27, 2, 3), 3, 0, 0,
              1, 25, 32'hcafe_0001, 1, 0, 0, '0, 0);
      add_row(mk_r(2, 26, 1, 2), mk_r(1, 27, 25, 3), 3, 0, 0,
              1, 25, 32'hcafe_0001, 1, 0, 0, '0, 1);
      add_row(mk_r(1, 26, 25, 1), mk_r(2, 28, 2, 25), 3, 0, 0,
              1, 25, 32'h1234_5678, 0, 0, 0, '0, 2);
      add_row(mk_r(1, 9, 5, 0), mk_r(3, 10, 0, 5), 3, 0, 0,
              1, 5, 32'haaaa_5555, 0, 1, 5, 32'h0bad_f00d, 2);
      add_row(mk_r(4, 11, 5, 5), mk_r(1, 12, 6, 7), 3, 0, 0, 0, 0, '0, 0, 0, 0, '0, 2);
      add_row(mk_r(1, 13, 14, 15), mk_r(1, 16, 17, 18), 3, 1, 0, 0, 0, '0, 0, 0, 0, '0, 0);
      add_row(mk_r(1, 1, 2, 3), mk_r(1, 4, 5, 6), 3, 0, 1, 0, 0, '0, 0, 0, 0, '0, 2);
      add_row(mk_i(5, 2, 0, 32'h7fff), mk_i(6, 3, 2, 4), 3, 0, 0, 0, 0, '0, 0, 0, 0, '0, 1);
      add_row(mk_r(1, 5, 6, 7), mk_r(1, 8, 9, 10), 3, 1, 1, 0, 0, '0, 0, 0, 0, '0, 0);
      add_row(mk_r(1, 5, 6, 7), mk_r(2, 8, 9, 10), 1, 0, 0, 0, 0, '0, 0, 0, 0, '0, 1);
      add_row(mk_r(1, 5, 6, 7), mk_r(2, 8, 9, 10), 0, 0, 0, 0, 0, '0, 0, 0, 0, '0, 0);
      add_row(mk_r(1, 13, 0, 2), mk_r(1, 14, 3, 4), 3, 0, 0,
              1, 0, 32'hffff_ffff, 1, 0, 0, '0, 2);
   endtask

   task automatic decode_ref(input insn_t ins, input logic v, output alu_opc_t alu,
                             output lsu_opc_t lsu, output bru_opc_t bru, output logic we,
                             output logic r1, output logic r2);
      alu = '0;
      lsu = '0;
      bru = '0;
      we  = 1'b0;
      r1  = 1'b0;
      r2  = 1'b0;
      if (v)
      begin
         case (ins[31:26])
            6'd1: {alu, we, r1, r2} = {4'b0001, 3'b111};
            6'd2: {alu, we, r1, r2} = {4'b0010, 3'b111};
            6'd3: {alu, we, r1, r2} = {4'b0100, 3'b111};
            6'd4: {alu, we, r1, r2} = {4'b1000, 3'b111};
            6'd5: {alu, we, r1, r2} = {4'b0001, 3'b110};
            6'd6: {lsu, we, r1, r2} = {2'b01, 3'b110};
            6'd7: {lsu, we, r1, r2} = {2'b10, 3'b011};
            6'd8: {bru, we, r1, r2} = {1'b1, 3'b011};
            default: we = 1'b0;
         endcase
      end
   endtask

   // s1 beats s3 beats the register file and r0 always reads zero
   function automatic data_t fwd_ref(input reg_addr_t a, input data_t rv, input row_t x);
      if (a == '0)
         return '0;
      if (x.s1we && (x.s1a == a))
         return x.s1d;
      if (x.s3we && (x.s3a == a))
         return x.s3d;
      return rv;
   endfunction

   task automatic apply_row(input int r);
      row_t x;
      x = rows[r];
      id_ins[0]   = x.i0;
      id_ins[1]   = x.i1;
      id_pc[0]    = slot_pc(r, 0);
      id_pc[1]    = slot_pc(r, 1);
      id_valid    = x.v;
      stall       = x.st;
      flush       = x.fl;
      s1_we       = {1'b0, x.s1we};
      s1_waddr[0] = x.s1a;
      s1_wdata[0] = x.s1d;
      s1_load0    = x.ld;
      s3_we       = {1'b0, x.s3we};
      s3_waddr[0] = x.s3a;
      s3_wdata[0] = x.s3d;
   endtask

   // What the next edge loads into the execute-side registers
   task automatic predict_row(input int r);
      row_t     x;
      insn_t    ins;
      alu_opc_t alu;
      lsu_opc_t lsu;
      bru_opc_t bru;
      logic     we;
      logic     r1;
      logic     r2;
      x = rows[r];
      if (x.s3we && (x.s3a != '0))
         model[x.s3a] = x.s3d;
      if (!x.st)
      begin
         for (int k = 0; k < `ISSUE_W; k++)
         begin
            ins = (k == 0) ? x.i0 : x.i1;
            decode_ref(ins, x.v[k], alu, lsu, bru, we, r1, r2);
            exp_alu[k]   = alu;
            exp_lsu[k]   = lsu;
            exp_bru[k]   = bru;
            exp_rf_we[k] = we & (ins[25:21] != 5'd0);
            exp_waddr[k] = ins[25:21];
            exp_imm[k]   = {{16{ins[15]}}, ins[15:0]};
            exp_pc[k]    = slot_pc(r, k);
            cap_r1[k]    = r1;
            cap_r2[k]    = r2;
            if (r1)
            begin
               cap_a1[k] = ins[20:16];
               cap_v1[k] = model[ins[20:16]];
            end
            if (r2)
            begin
               cap_a2[k] = ins[15:11];
               cap_v2[k] = model[ins[15:11]];
            end
         end
      end
      if (x.fl)
         exp_valid = '0;
      else if (!x.st)
         exp_valid = (x.pop == 2'd2) ? 2'b11 : ((x.pop == 2'd1) ? 2'b01 : 2'b00);
   endtask

   task automatic check_ex(input int r);
      row_t  x;
      data_t op2;
      x = rows[r];
      check_mask("ex_valid", exp_valid, ex_valid);
      check_mask("ex_rf_we", exp_rf_we, ex_rf_we);
      for (int k = 0; k < `ISSUE_W; k++)
      begin
         check_alu($sformatf("ex_alu_opc[%0d]", k), exp_alu[k], ex_alu_opc[k]);
         check_lsu($sformatf("ex_lsu_opc[%0d]", k), exp_lsu[k], ex_lsu_opc[k]);
         check_bru($sformatf("ex_bru_opc[%0d]", k), exp_bru[k], ex_bru_opc[k]);
         check_data($sformatf("ex_imm[%0d]", k), exp_imm[k], ex_imm[k]);
         check_pc($sformatf("ex_pc[%0d]", k), exp_pc[k], ex_pc[k]);
         check_addr($sformatf("ex_rf_waddr[%0d]", k), exp_waddr[k], ex_rf_waddr[k]);
         if (exp_valid[k] && cap_r1[k])
         begin
            check_data($sformatf("ex_operand1[%0d]", k),
                       fwd_ref(cap_a1[k], cap_v1[k], x), ex_operand1[k]);
            op2 = cap_r2[k] ? fwd_ref(cap_a2[k], cap_v2[k], x) : exp_imm[k];
            check_data($sformatf("ex_operand2[%0d]", k), op2, ex_operand2[k]);
         end
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while ((rst_n !== 1'b1) && (cycles < 10))
      begin
         @(posedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("Reset was not released within 10 clock cycles");
         abort_run();
      end
   endtask

   initial
   begin
      int    r;
      data_t w;
      lfsr     = 32'hd3feec52;
      flush    = 1'b0;
      stall    = 1'b0;
      id_valid = '0;
      id_ins   = '0;
      id_pc    = '0;
      s1_we    = '0;
      s2_we    = '0;
      s3_we    = '0;
      s1_waddr = '0;
      s2_waddr = '0;
      s3_waddr = '0;
      s1_wdata = '0;
      s2_wdata = '0;
      s3_wdata = '0;
      s1_load0 = 1'b0;
      for (r = 0; r < `REG_NUM; r++)
         model[r] = '0;
      build_table();
      wait_reset_release();
      #1;
      check_mask("ex_valid", '0, ex_valid);

      // Fill r1 to r31 through the writeback port
      for (r = 1; r < `REG_NUM; r++)
      begin
         @(posedge clk);
         #1;
         take_word(w);
         s3_we       = 2'b01;
         s3_waddr[0] = reg_addr_t'(r);
         s3_wdata[0] = w;
         model[r]    = w;
      end

      for (r = 0; r < rows.size(); r++)
      begin
         @(posedge clk);
         #1;
         if (r > 0)
            check_ex(r - 1);
         apply_row(r);
         predict_row(r);
         #1;
         check_pop("id_pop_cnt", rows[r].pop, id_pop_cnt);
      end
      @(posedge clk);
      #1;
      check_ex(rows.size() - 1);
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/issue_pkg.sv
hw/insn_dec.sv
hw/operand_bypass.sv
hw/arch_regfile.sv
hw/issue_stage.sv
hw/issue_top.sv
bench/tb_clock.sv
bench/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module issue_tb -f verilog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vissue_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation binary returned status $status"
   exit 1
fi

if echo "$out" | grep -q "Simulation passed"; then
   exit 0
else
   exit 1
fi
